// ==== bench/lc3b_checker.sv ====
module lc3b_checker
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  logic                   inst_ready,
    input  lc3b_types::lc3b_inst   inst,
    input  logic                   out_valid,
    input  logic                   out_ready,
    input  lc3b_types::lc3b_retire out,
    output int                     mismatch_count,
    output int                     protocol_count,
    output int                     pending
);
    timeunit 1ns;
    timeprecision 1ps;

    import lc3b_types::*;

    lc3b_word   regs [8];                                   // isa model state
    lc3b_word   mem [dmem_words];
    lc3b_cc     cc;
    lc3b_retire exp_q [$];                                  // oldest first
    lc3b_retire rec;
    logic       want_ready;                                 // expected inst_ready
    int         cycle;
    int         reset_edges;
    int         first_accept;                               // -1 until first accept

    function automatic lc3b_word sext(input lc3b_word v, input int bits);
        lc3b_word m;
        m = 16'hffff << bits;
        return v[bits-1] ? (v | m) : (v & ~m);
    endfunction

    // runs one instruction on the isa model and returns its retirement record
    task automatic model_step(input lc3b_inst i, output lc3b_retire r);
        lc3b_word a;
        lc3b_word b;
        lc3b_word addr;
        logic     writes;
        r        = '0;
        r.pc     = i.pc;
        a        = regs[i.ir[8:6]];
        b        = i.ir[5] ? sext(i.ir, 5) : regs[i.ir[2:0]];
        addr     = a + (sext(i.ir, 6) << 1);                // ldr/str word offset
        writes   = 1'b1;
        case (i.ir[15:12])
            op_add:  r.value = a + b;
            op_and:  r.value = a & b;
            op_not:  r.value = ~a;
            op_ldr:  r.value = mem[addr[5:1]];
            default: writes = 1'b0;
        endcase
        if (writes)
        begin
            r.regwrite        = 1'b1;
            r.dest            = i.ir[11:9];
            regs[i.ir[11:9]]  = r.value;
            cc = r.value[15] ? 3'b100 : ((r.value == '0) ? 3'b010 : 3'b001);
        end
        if (i.ir[15:12] == op_str)
        begin
            r.store          = 1'b1;
            r.store_addr     = addr;
            r.value          = regs[i.ir[11:9]];            // store data
            mem[addr[5:1]]   = r.value;
        end
        if (i.ir[15:12] == op_br && (i.ir[11:9] & cc) != 3'b000)
        begin
            r.branch_taken = 1'b1;
            r.target       = i.pc + 16'd2 + (sext(i.ir, 9) << 1);
        end
    endtask

    task automatic check_field(input string name, input lc3b_word got, input lc3b_word want);
        if (got !== want)
        begin
            $display("FAILED out.%s: got %h, expected %h (pc %h)", name, got, want, out.pc);
            mismatch_count++;
        end
    endtask

    task automatic compare(input lc3b_retire want);
        check_field("pc", out.pc, want.pc);                 // also catches reordering
        check_field("regwrite", 16'(out.regwrite), 16'(want.regwrite));
        check_field("dest", 16'(out.dest), 16'(want.dest));
        check_field("value", out.value, want.value);
        check_field("store", 16'(out.store), 16'(want.store));
        check_field("store_addr", out.store_addr, want.store_addr);
        check_field("branch_taken", 16'(out.branch_taken), 16'(want.branch_taken));
        check_field("target", out.target, want.target);
    endtask

    initial
    begin
        mismatch_count = 0;
        protocol_count = 0;
        pending        = 0;
        cycle          = 0;
        reset_edges    = 0;
        first_accept   = -1;
    end

    always @(posedge clk)
    begin
        cycle++;
        if (reset)
        begin
            if (reset_edges > 0 && out_valid !== 1'b0)      // first edge still unknown
            begin
                $display("out_valid was not low during reset at cycle %0d", cycle);
                protocol_count++;
            end
            reset_edges++;
            for (int k = 0; k < 8; k++)
                regs[k] = '0;
            for (int k = 0; k < dmem_words; k++)
                mem[k] = '0;
            cc = cc_reset;
            exp_q.delete();
            first_accept = -1;
        end
        else
        begin
            // two slots, a full pipe only takes more when the tail drains
            want_ready = exp_q.size() < 2 || out_ready;
            if (inst_ready !== want_ready)
            begin
                $display("FAILED inst_ready: got %h, expected %h with %0d in flight",
                         inst_ready, want_ready, exp_q.size());
                protocol_count++;
            end
            if (out_valid && out_ready)                     // retire before accept
            begin
                if (exp_q.size() == 0)
                begin
                    $display("record for pc %h retired with nothing outstanding", out.pc);
                    protocol_count++;
                end
                else
                    compare(exp_q.pop_front());
                if (first_accept >= 0 && cycle - first_accept != 2)
                begin
                    $display("first retirement came %0d edges after its acceptance, not 2",
                             cycle - first_accept);
                    protocol_count++;
                end
                first_accept = -2;                          // latency checked once
            end
            if (inst_valid && inst_ready)
            begin
                model_step(inst, rec);
                exp_q.push_back(rec);
                if (first_accept == -1)
                    first_accept = cycle;
            end
        end
        pending = exp_q.size();
    end

endmodule : lc3b_checker

// ==== bench/tb_lc3b.sv ====
module tb_lc3b;
    timeunit 1ns;
    timeprecision 1ps;

    import lc3b_types::*;

    localparam int random_count = 540;                      // about 600 with the directed ones
    localparam int accept_limit = 100;                      // cycles per instruction
    localparam int drain_limit  = 200;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic        inst_ready;
    lc3b_inst    inst;
    logic        out_valid;
    logic        out_ready;
    lc3b_retire  out_rec;
    logic [31:0] lfsr;
    lc3b_word    pc;                                        // next pc handed out
    logic        stalls_on;                                 // random out_ready
    int          timeouts;
    int          mismatch_count;
    int          protocol_count;
    int          pending;

    lc3b_core uut
    (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out        (out_rec)
    );

    lc3b_checker chk
    (
        .clk            (clk),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst           (inst),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out            (out_rec),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count),
        .pending        (pending)
    );

    always #50 clk = ~clk;                                  // 100 ns period

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};      // taps 32 22 2 1
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr_next(lfsr);                         // one step per bit
            r    = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic next_out_ready;
        out_ready = stalls_on ? (take_bits(2) != 16'd0) : 1'b1;     // 3/4 ready
    endtask

    // starts on a falling edge and returns on the falling edge after acceptance
    task automatic send(input lc3b_word ir);
        int   waited;
        logic took;
        inst_valid = 1'b1;
        inst.pc    = pc;
        inst.ir    = ir;
        took       = 1'b0;
        waited     = 0;
        while (!took && waited < accept_limit)
        begin
            @(posedge clk);
            took = inst_ready;
            @(negedge clk);
            next_out_ready();
            waited++;
        end
        inst_valid = 1'b0;
        pc         = pc + 16'd2;
        if (!took)
        begin
            $display("timeout: instruction at pc %h not accepted in %0d cycles",
                     inst.pc, accept_limit);
            timeouts++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            @(negedge clk);
            next_out_ready();
        end
    endtask

    task automatic drain;
        int waited;
        stalls_on = 1'b0;
        out_ready = 1'b1;
        waited    = 0;
        while (pending != 0 && waited < drain_limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0)
        begin
            $display("timeout: %0d records still outstanding after %0d cycles",
                     pending, drain_limit);
            timeouts++;
        end
    endtask

    task automatic send_random;
        logic [3:0] kind;
        logic [3:0] op;
        logic [2:0] dr;
        logic [2:0] sr;
        logic [5:0] off6;
        logic       imm_form;
        kind     = 4'(take_bits(4));
        dr       = 3'(take_bits(3));
        sr       = 3'(take_bits(3));
        imm_form = 1'(take_bits(1));
        if (dr == 3'd7)
            dr = 3'd6;                                      // r7 stays zero
        case (kind)
            4'd0, 4'd1, 4'd2: send({op_add, dr, sr, imm_form, 5'(take_bits(5))});
            4'd3, 4'd4:       send({op_and, dr, sr, imm_form, 5'(take_bits(5))});
            4'd5:             send({op_not, dr, sr, 6'h3f});
            4'd6, 4'd7:       send({op_ldr, dr, sr, 6'(take_bits(6))});
            4'd8, 4'd9:
            begin
                off6 = 6'(take_bits(6));
                send({op_and, 3'd6, sr, 1'b1, 5'h1e});      // even base in r6
                send({op_str, 3'(take_bits(3)), 3'd6, off6});
                if (take_bits(1) != 16'd0)
                    send({op_ldr, dr, 3'd6, off6});         // read it back
            end
            4'd10, 4'd11, 4'd12: send({op_br, 3'(take_bits(3)), 9'(take_bits(9))});
            default:
            begin
                op = {1'b1, 3'(take_bits(3))};
                if (op == op_not)
                    op = 4'b0010;                           // ldb is not supported
                send({op, 12'(take_bits(12))});
            end
        endcase
    endtask

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        out_ready  = 1'b1;
        lfsr       = 32'h7cc2_d56e;
        pc         = 16'h3000;
        stalls_on  = 1'b0;
        timeouts   = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        send({op_ldr, 3'd1, 3'd7, 6'd9});                   // lone instruction for latency
        drain();
        for (int a = 0; a < dmem_words; a++)
            send({op_ldr, 3'd1, 3'd7, 6'(a)});              // every word reads zero
        for (int k = 0; k < 8; k++)
            send({op_add, 3'd2, 3'd2, 1'b1, 5'd3});         // forwarding chain on r2
        stalls_on = 1'b1;
        for (int k = 0; k < random_count && timeouts == 0; k++)
        begin
            send_random();
            if (take_bits(3) == 16'd0)
                idle(1 + int'(take_bits(2)));               // bubble on input
        end
        drain();
        idle(4);                                            // catch late duplicates
        $display("errors: %0d field mismatches, %0d protocol, %0d timeouts",
                 mismatch_count, protocol_count, timeouts);
        if (mismatch_count == 0 && protocol_count == 0 && timeouts == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule : tb_lc3b

// ==== files.f ====
src/lc3b_types.sv
src/cpu_control.sv
src/regfile.sv
src/data_mem.sv
src/pipe_stage.sv
src/execute_stage.sv
src/lc3b_core.sv
bench/lc3b_checker.sv
bench/tb_lc3b.sv

// ==== src/cpu_control.sv ====
module cpu_control
(
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         ir_5,
    output lc3b_types::lc3b_control_word cw
);

    import lc3b_types::*;

    always_comb
    begin
        // no-op word first and the opcodes below only raise what they need
        cw.opcode         = opcode;
        cw.aluop          = alu_pass;
        cw.alumux_sel     = alumux_src2;
        cw.src2mux_sel    = 1'b0;                       // sr2 from ir[2:0]
        cw.regfilemux_sel = regfilemux_alu;
        cw.load_regfile   = 1'b0;
        cw.load_cc        = 1'b0;
        cw.dmem_read      = 1'b0;
        cw.dmem_write     = 1'b0;
        cw.is_branch      = 1'b0;

        case (opcode)
            op_add:
            begin
                cw.aluop = alu_add;
                if (ir_5)                               // addi
                begin
                    cw.alumux_sel = alumux_imm5;
                end
                else                                    // addr
                begin
                    cw.alumux_sel = alumux_src2;
                end
                cw.regfilemux_sel = regfilemux_alu;
                cw.load_regfile   = 1'b1;
                cw.load_cc        = 1'b1;
            end

            op_and:
            begin
                cw.aluop = alu_and;
                if (ir_5)                               // andi
                begin
                    cw.alumux_sel = alumux_imm5;
                end
                else                                    // andr
                begin
                    cw.alumux_sel = alumux_src2;
                end
                cw.regfilemux_sel = regfilemux_alu;
                cw.load_regfile   = 1'b1;
                cw.load_cc        = 1'b1;
            end

            op_not:
            begin
                cw.aluop          = alu_not;            // only sr1 used
                cw.regfilemux_sel = regfilemux_alu;
                cw.load_regfile   = 1'b1;
                cw.load_cc        = 1'b1;
            end

            op_ldr:
            begin
                cw.aluop          = alu_add;            // base + adj6
                cw.alumux_sel     = alumux_adj6;
                cw.dmem_read      = 1'b1;
                cw.regfilemux_sel = regfilemux_mem;     // load data to dr
                cw.load_regfile   = 1'b1;
                cw.load_cc        = 1'b1;
            end

            op_str:
            begin
                cw.aluop       = alu_add;               // base + adj6
                cw.alumux_sel  = alumux_adj6;
                cw.src2mux_sel = 1'b1;                  // sr sits in dr field
                cw.dmem_write  = 1'b1;
            end

            op_br:
            begin
                cw.is_branch = 1'b1;                    // nzp test in execute
            end

            default:
            begin
                cw.is_branch = 1'b0;                    // unsupported opcode retires as no-op
            end
        endcase
    end

endmodule : cpu_control

// ==== src/data_mem.sv ====
module data_mem
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write,
    input  lc3b_types::lc3b_word addr,
    input  lc3b_types::lc3b_word wdata,
    output lc3b_types::lc3b_word rdata
);

    import lc3b_types::*;

    lc3b_word                  mem [dmem_words];
    logic [dmem_addr_bits-1:0] index;                   // word index without bit 0

    assign index = addr[dmem_addr_bits:1];              // upper bits alias
    assign rdata = mem[index];                          // async read

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < dmem_words; i++)
                mem[i] <= '0;
        end
        else if (write)
        begin
            mem[index] <= wdata;
        end
    end

    odd_store_addr: assert property (@(posedge clk) disable iff (reset)
        write |-> !addr[0])
        else $error("data_mem: word store to odd address %h", addr);

endmodule : data_mem

// ==== src/execute_stage.sv ====
module execute_stage
(
    input  logic                    clk,
    input  logic                    reset,
    input  lc3b_types::lc3b_decoded dec,
    input  logic                    dec_valid,
    input  logic                    advance,
    input  lc3b_types::lc3b_retire  fwd,
    input  logic                    fwd_valid,
    output lc3b_types::lc3b_retire  result
);

    import lc3b_types::*;

    lc3b_reg  sr1;
    lc3b_reg  sr2;
    lc3b_word src1;                                     // after forwarding
    lc3b_word src2;
    lc3b_word imm5;
    lc3b_word adj6;
    lc3b_word offset9;
    lc3b_word alu_b;
    lc3b_word alu_out;
    lc3b_word mem_rdata;
    lc3b_word load_data;
    lc3b_word wb_value;                                 // word written to dr
    lc3b_cc   cc;
    lc3b_cc   cc_next;
    logic     commit;                                   // record moves into er_reg
    logic     taken;

    assign commit = advance && dec_valid;

    assign sr1 = dec.ir[8:6];
    assign sr2 = dec.cw.src2mux_sel ? dec.ir[11:9] : dec.ir[2:0];   // same pick as decode

    // retiring record is newer than what decode read
    assign src1 = (fwd_valid && fwd.regwrite && fwd.dest == sr1) ? fwd.value : dec.src1_data;
    assign src2 = (fwd_valid && fwd.regwrite && fwd.dest == sr2) ? fwd.value : dec.src2_data;

    assign imm5    = {{11{dec.ir[4]}}, dec.ir[4:0]};
    assign adj6    = {{9{dec.ir[5]}}, dec.ir[5:0], 1'b0};            // word offset
    assign offset9 = {{6{dec.ir[8]}}, dec.ir[8:0], 1'b0};

    always_comb
    begin
        case (dec.cw.alumux_sel)
            alumux_imm5: alu_b = imm5;
            alumux_adj6: alu_b = adj6;
            default:     alu_b = src2;
        endcase
    end

    always_comb
    begin
        case (dec.cw.aluop)
            alu_add: alu_out = src1 + alu_b;
            alu_and: alu_out = src1 & alu_b;
            alu_not: alu_out = ~src1;
            default: alu_out = src1;                    // pass
        endcase
    end

    data_mem dmem
    (
        .clk   (clk),
        .reset (reset),
        .write (commit && dec.cw.dmem_write),           // once per store
        .addr  (alu_out),
        .wdata (src2),                                  // str source reg
        .rdata (mem_rdata)
    );

    assign load_data = dec.cw.dmem_read ? mem_rdata : '0;
    assign wb_value  = (dec.cw.regfilemux_sel == regfilemux_mem) ? load_data : alu_out;

    always_comb
    begin
        if (wb_value[15])
            cc_next = 3'b100;                           // n
        else if (wb_value == '0)
            cc_next = 3'b010;                           // z
        else
            cc_next = 3'b001;                           // p
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            cc <= cc_reset;
        else if (commit && dec.cw.load_cc)
            cc <= cc_next;
    end

    assign taken = dec.cw.is_branch && |(dec.ir[11:9] & cc);        // nzp meets cc

    always_comb
    begin
        result              = '0;
        result.pc           = dec.pc;
        result.regwrite     = dec.cw.load_regfile;
        result.store        = dec.cw.dmem_write;
        result.branch_taken = taken;
        if (dec.cw.load_regfile)
        begin
            result.dest  = dec.ir[11:9];
            result.value = wb_value;
        end
        if (dec.cw.dmem_write)
        begin
            result.store_addr = alu_out;
            result.value      = src2;                   // store data
        end
        if (taken)
            result.target = dec.pc + 16'd2 + offset9;
    end

    advance_has_data: assert property (@(posedge clk) disable iff (reset)
        advance |-> dec_valid)
        else $error("execute_stage: er_reg loaded without a decoded instruction");

endmodule : execute_stage

// ==== src/lc3b_core.sv ====
module lc3b_core
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    output logic                   inst_ready,
    input  lc3b_types::lc3b_inst   inst,
    output logic                   out_valid,
    input  logic                   out_ready,
    output lc3b_types::lc3b_retire out
);

    import lc3b_types::*;

    lc3b_opcode       opcode;
    lc3b_control_word cw;
    lc3b_reg          src_b;                            // second read index
    lc3b_word         reg_a;
    lc3b_word         reg_b;
    lc3b_decoded      dec_in;
    lc3b_decoded      dec_out;
    logic             dec_valid;                        // de_reg holds an instruction
    logic             er_ready;
    logic             advance;                          // de_reg -> er_reg transfer
    logic             retire;                           // out handshake
    lc3b_retire       exe_result;

    assign opcode  = lc3b_opcode'(inst.ir[15:12]);
    assign src_b   = cw.src2mux_sel ? inst.ir[11:9] : inst.ir[2:0];    // str reads dr field
    assign advance = dec_valid && er_ready;
    assign retire  = out_valid && out_ready;

    cpu_control ctrl
    (
        .opcode (opcode),
        .ir_5   (inst.ir[5]),                           // imm5 form select
        .cw     (cw)
    );

    regfile rf
    (
        .clk   (clk),
        .reset (reset),
        .load  (retire && out.regwrite),                // write at retirement
        .dest  (out.dest),
        .in    (out.value),
        .src_a (inst.ir[8:6]),
        .src_b (src_b),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    assign dec_in = '{cw: cw, ir: inst.ir, pc: inst.pc, src1_data: reg_a, src2_data: reg_b};

    pipe_stage #(.payload_t(lc3b_decoded)) de_reg
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (inst_valid),
        .in_ready  (inst_ready),
        .in        (dec_in),
        .out_valid (dec_valid),
        .out_ready (er_ready),
        .out       (dec_out)
    );

    execute_stage exe
    (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec_out),
        .dec_valid (dec_valid),
        .advance   (advance),
        .fwd       (out),                               // forward from retirement reg
        .fwd_valid (out_valid),
        .result    (exe_result)
    );

    pipe_stage #(.payload_t(lc3b_retire)) er_reg
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dec_valid),
        .in_ready  (er_ready),
        .in        (exe_result),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

endmodule : lc3b_core

// ==== src/lc3b_types.sv ====
package lc3b_types;

    localparam int dmem_words     = 32;                 // data memory depth in words
    localparam int dmem_addr_bits = $clog2(dmem_words); // word index width

    typedef logic [15:0] lc3b_word;                     // data and address
    typedef logic [2:0]  lc3b_reg;                      // register index
    typedef logic [2:0]  lc3b_cc;                       // n z p

    localparam lc3b_cc cc_reset = 3'b010;               // z only

    typedef enum logic [3:0]
    {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;                                      // others retire as no-op

    typedef enum logic [1:0]
    {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11                                // a straight through
    } lc3b_aluop;

    localparam logic [1:0] alumux_src2 = 2'b00;         // second register operand
    localparam logic [1:0] alumux_imm5 = 2'b01;         // sext(imm5)
    localparam logic [1:0] alumux_adj6 = 2'b10;         // sext(offset6) << 1

    localparam logic regfilemux_alu = 1'b0;             // write alu result
    localparam logic regfilemux_mem = 1'b1;             // write load data

    typedef struct packed
    {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic [1:0] alumux_sel;
        logic       src2mux_sel;                        // dest field is the source for str
        logic       regfilemux_sel;
        logic       load_regfile;
        logic       load_cc;
        logic       dmem_read;
        logic       dmem_write;
        logic       is_branch;                          // taken decided in execute
    } lc3b_control_word;

    typedef struct packed
    {
        lc3b_word pc;
        lc3b_word ir;
    } lc3b_inst;                                        // input stream payload

    typedef struct packed
    {
        lc3b_control_word cw;
        lc3b_word         ir;
        lc3b_word         pc;
        lc3b_word         src1_data;                    // sr1 as read in decode
        lc3b_word         src2_data;                    // sr2 or str source
    } lc3b_decoded;                                     // decode to execute

    // value holds the written word on a register write and the store data on a store
    // fields an instruction does not use stay zero
    typedef struct packed
    {
        lc3b_word pc;
        logic     regwrite;
        lc3b_reg  dest;
        lc3b_word value;
        logic     store;
        lc3b_word store_addr;
        logic     branch_taken;
        lc3b_word target;
    } lc3b_retire;                                      // output stream payload

endpackage : lc3b_types

// ==== src/pipe_stage.sv ====
module pipe_stage
#(
    parameter type payload_t = logic [31:0]
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out
);

    logic     full;                                     // slot occupied
    payload_t data;

    assign in_ready  = !full || out_ready;              // empty or draining now
    assign out_valid = full;
    assign out       = data;

    always_ff @(posedge clk)
    begin
        if (reset)
            full <= 1'b0;
        else if (in_valid && in_ready)
            full <= 1'b1;                               // refill even while draining
        else if (out_ready)
            full <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
            data <= in;
    end

    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else $error("pipe_stage: output dropped or changed while stalled");

    valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(out_valid))
        else $error("pipe_stage: out_valid unknown");

endmodule : pipe_stage

// ==== src/regfile.sv ====
module regfile
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word in,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);

    import lc3b_types::*;

    lc3b_word data [8];                                 // r0..r7

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
                data[i] <= '0;                          // all registers zero
        end
        else if (load)
        begin
            data[dest] <= in;
        end
    end

    // same-cycle write wins so decode sees the retiring value
    assign reg_a = (load && dest == src_a) ? in : data[src_a];
    assign reg_b = (load && dest == src_b) ? in : data[src_b];

endmodule : regfile
